//--- list.f
verilog/glay_pkg.sv
verilog/kernel_control.sv
verilog/cluster_engine.sv
verilog/sum_reduce.sv
verilog/glay_top.sv
bench/tb_glay_top.sv

//--- Makefile
# Verilator flow for the vertex-walk overlay

VERILATOR ?= verilator
TOP       ?= tb_glay_top
RTL_TOP   ?= glay_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= === PASS ===

.PHONY: all lint build sim clean

all: sim

# Lint the whole tree from the testbench top
lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR)

# Pass only when the pass message shows up in the output
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F -- "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/tb_glay_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_glay_top;

    import glay_pkg::*;

    localparam int NUM_GRAPH_CLUSTERS = 4;
    localparam int SETUP_CYCLES       = 8;
    localparam int CLK_PERIOD         = 100;

    // Watchdog length from the fixed and chained random runs
    localparam int NUM_RANDOM_RUNS = 8;
    localparam int NUM_RUNS        = 4 + NUM_RANDOM_RUNS;
    localparam int MAX_COUNT       = 200;
    localparam int RUN_OVERHEAD    = 50;
    localparam int TIMEOUT_CYCLES  = NUM_RUNS * (MAX_COUNT + RUN_OVERHEAD) + 500;

    logic                ap_clk;
    logic                control_areset;
    logic                ap_start;
    logic                ap_continue;
    logic [VERTEX_W-1:0] vertex_base;
    logic [VERTEX_W-1:0] vertex_count;
    logic                ap_ready;
    logic                ap_done;
    logic                ap_idle;
    logic [SUM_W-1:0]    result_sum;

    // LCG state and ap_ready pulse counter
    logic [31:0] lcg_state;
    int          ready_count;

    glay_top #(
        .NUM_GRAPH_CLUSTERS(NUM_GRAPH_CLUSTERS),
        .SETUP_CYCLES      (SETUP_CYCLES)
    ) DUT (
        .ap_clk        (ap_clk),
        .control_areset(control_areset),
        .ap_start      (ap_start),
        .ap_continue   (ap_continue),
        .vertex_base   (vertex_base),
        .vertex_count  (vertex_count),
        .ap_ready      (ap_ready),
        .ap_done       (ap_done),
        .ap_idle       (ap_idle),
        .result_sum    (result_sum)
    );

    // ----------------------------------------
    // Clock, watchdog, monitors
    // ----------------------------------------

    always #(CLK_PERIOD / 2) ap_clk = ~ap_clk;

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("=== FAIL ===");
        $fatal(1);
    end

    // Count ap_ready pulses between clock edges
    always @(negedge ap_clk) begin
        if (ap_ready) begin
            ready_count = ready_count + 1;
        end
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Sum of base+i for i below count modulo 2^32
    function automatic logic [SUM_W-1:0] expected_sum(input logic [VERTEX_W-1:0] base,
                                                      input logic [VERTEX_W-1:0] count);
        logic [63:0] b;
        logic [63:0] c;
        logic [63:0] total;
        b = 64'(base);
        c = 64'(count);
        if (c == 64'd0) begin
            total = 64'd0;
        end else begin
            total = c * b + (c * (c - 64'd1)) / 64'd2;
        end
        return total[SUM_W-1:0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%08h, expected 0x%08h", name, actual, expected);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    // One start/ready/done sequence starting on a falling edge
    task automatic run_one(input logic [VERTEX_W-1:0] base,
                           input logic [VERTEX_W-1:0] count);
        vertex_base  = base;
        vertex_count = count;
        ap_start     = 1'b1;
        // Level start held until accepted
        while (ap_ready !== 1'b1) begin
            @(negedge ap_clk);
        end
        ap_start = 1'b0;
        check_value("ap_idle", 32'(ap_idle), 32'd0);
        while (ap_done !== 1'b1) begin
            @(negedge ap_clk);
        end
        check_value("result_sum", result_sum, expected_sum(base, count));
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------

    task automatic check_reset_state();
        check_value("ap_idle", 32'(ap_idle), 32'd1);
        check_value("ap_ready", 32'(ap_ready), 32'd0);
        check_value("ap_done", 32'(ap_done), 32'd0);
        check_value("result_sum", result_sum, 32'd0);
    endtask

    task automatic single_run();
        ready_count = 0;
        run_one(16'd10, 16'd37);
        // Exactly one accept for the whole run
        check_value("ap_ready pulses", 32'(ready_count), 32'd1);
    endtask

    task automatic hold_and_continue();
        repeat (20) begin
            @(negedge ap_clk);
            check_value("ap_done", 32'(ap_done), 32'd1);
        end
        // Continue pulse restarts with the unchanged descriptor
        ap_continue = 1'b1;
        @(negedge ap_clk);
        ap_continue = 1'b0;
        while (ap_ready !== 1'b1) begin
            @(negedge ap_clk);
        end
        check_value("ap_idle", 32'(ap_idle), 32'd0);
        while (ap_done !== 1'b1) begin
            @(negedge ap_clk);
        end
        check_value("result_sum", result_sum, expected_sum(16'd10, 16'd37));
    endtask

    task automatic edge_counts();
        run_one(16'd55, 16'd0);
        run_one(16'd1234, 16'd1);
    endtask

    task automatic chained_random();
        logic [VERTEX_W-1:0] rand_base;
        logic [VERTEX_W-1:0] rand_count;
        for (int i = 0; i < NUM_RANDOM_RUNS; i++) begin
            lcg_state  = lcg_next(lcg_state);
            rand_base  = lcg_state[31:16] % 16'd200;
            lcg_state  = lcg_next(lcg_state);
            rand_count = lcg_state[31:16] % 16'd200;
            // New start chains on the previous done
            run_one(rand_base, rand_count);
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        ap_clk         = 1'b0;
        control_areset = 1'b1;
        ap_start       = 1'b0;
        ap_continue    = 1'b0;
        vertex_base    = '0;
        vertex_count   = '0;
        lcg_state      = 32'hccfc;
        ready_count    = 0;

        repeat (3) @(negedge ap_clk);
        control_areset = 1'b0;

        check_reset_state();
        single_run();
        hold_and_continue();
        edge_counts();
        chained_random();

        @(negedge ap_clk);
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/glay_top.sv
`timescale 1ns/100ps
`default_nettype none

module glay_top #(
    parameter int NUM_GRAPH_CLUSTERS = 4,
    parameter int SETUP_CYCLES       = 8
) (
    input  logic                          ap_clk,
    input  logic                          control_areset,
    input  logic                          ap_start,
    input  logic                          ap_continue,
    input  logic [glay_pkg::VERTEX_W-1:0] vertex_base,
    input  logic [glay_pkg::VERTEX_W-1:0] vertex_count,
    output logic                          ap_ready,
    output logic                          ap_done,
    output logic                          ap_idle,
    output logic [glay_pkg::SUM_W-1:0]    result_sum
);

    import glay_pkg::*;

    // Descriptor broadcast
    logic                desc_valid;
    logic [VERTEX_W-1:0] desc_base;
    logic [VERTEX_W-1:0] desc_count;

    // Per-cluster status, one bit each
    logic [NUM_GRAPH_CLUSTERS-1:0] cu_setup;
    logic [NUM_GRAPH_CLUSTERS-1:0] cu_done;

    // Partial sums, cluster k in word k
    logic [NUM_GRAPH_CLUSTERS*SUM_W-1:0] partial_sums;

    // ----------------------------------------
    // Kernel controller
    // ----------------------------------------

    kernel_control #(
        .NUM_GRAPH_CLUSTERS(NUM_GRAPH_CLUSTERS)
    ) u_kernel_control (
        .ap_clk        (ap_clk),
        .control_areset(control_areset),
        .ap_start      (ap_start),
        .ap_continue   (ap_continue),
        .vertex_base   (vertex_base),
        .vertex_count  (vertex_count),
        .cu_setup      (cu_setup),
        .cu_done       (cu_done),
        .ap_ready      (ap_ready),
        .ap_done       (ap_done),
        .ap_idle       (ap_idle),
        .desc_valid    (desc_valid),
        .desc_base     (desc_base),
        .desc_count    (desc_count)
    );

    // ----------------------------------------
    // Cluster array
    // ----------------------------------------

    genvar k;

    generate
        for (k = 0; k < NUM_GRAPH_CLUSTERS; k++) begin : g_cluster
            // Cluster k walks indices k, k+N, k+2N and so on
            cluster_engine #(
                .NUM_GRAPH_CLUSTERS(NUM_GRAPH_CLUSTERS),
                .SETUP_CYCLES      (SETUP_CYCLES),
                .CLUSTER_ID        (k)
            ) u_cluster_engine (
                .ap_clk        (ap_clk),
                .control_areset(control_areset),
                .desc_valid    (desc_valid),
                .desc_base     (desc_base),
                .desc_count    (desc_count),
                .cu_setup      (cu_setup[k]),
                .cu_done       (cu_done[k]),
                .partial_sum   (partial_sums[k*SUM_W +: SUM_W])
            );
        end
    endgenerate

    // ----------------------------------------
    // Reduction
    // ----------------------------------------

    sum_reduce #(
        .NUM_GRAPH_CLUSTERS(NUM_GRAPH_CLUSTERS)
    ) u_sum_reduce (
        .ap_clk        (ap_clk),
        .control_areset(control_areset),
        .partial_sums  (partial_sums),
        .result_sum    (result_sum)
    );

endmodule : glay_top

`default_nettype wire

//--- verilog/sum_reduce.sv
`timescale 1ns/100ps
`default_nettype none

module sum_reduce #(
    parameter int NUM_GRAPH_CLUSTERS = 4
) (
    input  logic                                       ap_clk,
    input  logic                                       control_areset,
    input  logic [NUM_GRAPH_CLUSTERS*glay_pkg::SUM_W-1:0] partial_sums,
    output logic [glay_pkg::SUM_W-1:0]                 result_sum
);

    import glay_pkg::*;

    // Tree depth, one register per level
    localparam int LEVELS = (NUM_GRAPH_CLUSTERS > 1) ? $clog2(NUM_GRAPH_CLUSTERS) : 0;
    // Leaves padded to a power of two
    localparam int LEAVES = 1 << LEVELS;

    genvar g;

    generate
        if (LEVELS == 0) begin : g_single
            // Single cluster, sum already registered in the cluster
            assign result_sum = partial_sums[SUM_W-1:0];
        end else begin : g_tree
            // Heap order, node k has children 2k+1 and 2k+2
            logic [SUM_W-1:0] tree_node [2*LEAVES-1];
            logic [SUM_W-1:0] node_q    [LEAVES-1];

            // Internal nodes come from the adder registers
            for (g = 0; g < LEAVES - 1; g++) begin : g_inner
                assign tree_node[g] = node_q[g];
            end

            // Leaves, unused slots read as zero
            for (g = 0; g < LEAVES; g++) begin : g_leaf
                if (g < NUM_GRAPH_CLUSTERS) begin : g_used
                    assign tree_node[LEAVES-1+g] = partial_sums[g*SUM_W +: SUM_W];
                end else begin : g_pad
                    assign tree_node[LEAVES-1+g] = '0;
                end
            end

            // Pairwise adds, wrapping at SUM_W
            always_ff @(posedge ap_clk) begin
                if (control_areset) begin
                    for (int k = 0; k < LEAVES - 1; k++) begin
                        node_q[k] <= '0;
                    end
                end else begin
                    for (int k = 0; k < LEAVES - 1; k++) begin
                        node_q[k] <= tree_node[2*k+1] + tree_node[2*k+2];
                    end
                end
            end

            assign result_sum = tree_node[0];
        end
    endgenerate

endmodule : sum_reduce

`default_nettype wire

//--- verilog/cluster_engine.sv
`timescale 1ns/100ps
`default_nettype none

module cluster_engine #(
    parameter int NUM_GRAPH_CLUSTERS = 4,
    parameter int SETUP_CYCLES       = 8,
    parameter int CLUSTER_ID         = 0
) (
    input  logic                          ap_clk,
    input  logic                          control_areset,
    input  logic                          desc_valid,
    input  logic [glay_pkg::VERTEX_W-1:0] desc_base,
    input  logic [glay_pkg::VERTEX_W-1:0] desc_count,
    output logic                          cu_setup,
    output logic                          cu_done,
    output logic [glay_pkg::SUM_W-1:0]    partial_sum
);

    import glay_pkg::*;

    // Extra bit so the stride cannot wrap past the count
    localparam int IDX_W   = VERTEX_W + 1;
    localparam int CLEAR_W = $clog2(SETUP_CYCLES + 1);

    cluster_state_t state;

    logic [CLEAR_W-1:0]  clear_count;
    logic [IDX_W-1:0]    vertex_idx;
    // Descriptor copy for this run
    logic [VERTEX_W-1:0] base_q;
    logic [VERTEX_W-1:0] count_q;

    // ----------------------------------------
    // Run descriptor and walk index
    // ----------------------------------------

    always_ff @(posedge ap_clk) begin
        if (state == CLUSTER_WAIT && desc_valid) begin
            base_q     <= desc_base;
            count_q    <= desc_count;
            // First vertex of this cluster's stripe
            vertex_idx <= IDX_W'(CLUSTER_ID);
        end else if (state == CLUSTER_WALK) begin
            vertex_idx <= vertex_idx + IDX_W'(NUM_GRAPH_CLUSTERS);
        end
    end

    // ----------------------------------------
    // Cluster FSM
    // ----------------------------------------

    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            state       <= CLUSTER_CLEAR;
            clear_count <= '0;
            cu_setup    <= 1'b1;
            cu_done     <= 1'b0;
            partial_sum <= '0;
        end else begin
            case (state)
                CLUSTER_CLEAR: begin
                    // Scratch clearing, one count per cycle
                    partial_sum <= '0;
                    if (clear_count == CLEAR_W'(SETUP_CYCLES - 1)) begin
                        cu_setup <= 1'b0;
                        state    <= CLUSTER_WAIT;
                    end else begin
                        clear_count <= clear_count + 1'b1;
                    end
                end
                CLUSTER_WAIT: begin
                    if (desc_valid) begin
                        // Previous result stays visible until here
                        partial_sum <= '0;
                        state       <= CLUSTER_WALK;
                    end
                end
                CLUSTER_WALK: begin
                    if (vertex_idx < {1'b0, count_q}) begin
                        // Vertex id is base plus index
                        partial_sum <= partial_sum + SUM_W'(base_q) + SUM_W'(vertex_idx);
                    end else begin
                        // Stripe exhausted
                        cu_done <= 1'b1;
                        state   <= CLUSTER_HOLD;
                    end
                end
                CLUSTER_HOLD: begin
                    // Controller drops valid once it sees all done
                    if (!desc_valid) begin
                        cu_done <= 1'b0;
                        state   <= CLUSTER_WAIT;
                    end
                end
                default: begin
                    state <= CLUSTER_CLEAR;
                end
            endcase
        end
    end

endmodule : cluster_engine

`default_nettype wire

//--- verilog/kernel_control.sv
`timescale 1ns/100ps
`default_nettype none

module kernel_control #(
    parameter int NUM_GRAPH_CLUSTERS = 4
) (
    input  logic                          ap_clk,
    input  logic                          control_areset,
    input  logic                          ap_start,
    input  logic                          ap_continue,
    input  logic [glay_pkg::VERTEX_W-1:0] vertex_base,
    input  logic [glay_pkg::VERTEX_W-1:0] vertex_count,
    input  logic [NUM_GRAPH_CLUSTERS-1:0] cu_setup,
    input  logic [NUM_GRAPH_CLUSTERS-1:0] cu_done,
    output logic                          ap_ready,
    output logic                          ap_done,
    output logic                          ap_idle,
    output logic                          desc_valid,
    output logic [glay_pkg::VERTEX_W-1:0] desc_base,
    output logic [glay_pkg::VERTEX_W-1:0] desc_count
);

    import glay_pkg::*;

    // Registered host and cluster inputs
    logic                          start_q;
    logic                          continue_q;
    logic [NUM_GRAPH_CLUSTERS-1:0] cu_setup_q;
    logic [NUM_GRAPH_CLUSTERS-1:0] cu_done_q;

    // First flag stage, decoded from the state
    logic ready_s1;
    logic done_s1;
    logic idle_s1;
    logic valid_s1;

    // First descriptor stage
    logic [VERTEX_W-1:0] base_s1;
    logic [VERTEX_W-1:0] count_s1;

    ctrl_state_t current_state;
    ctrl_state_t next_state;

    // ----------------------------------------
    // Input register stage
    // ----------------------------------------

    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            start_q    <= 1'b0;
            continue_q <= 1'b0;
            // Treat clusters as still clearing until told otherwise
            cu_setup_q <= '1;
            cu_done_q  <= '0;
        end else begin
            start_q    <= ap_start;
            continue_q <= ap_continue;
            cu_setup_q <= cu_setup;
            cu_done_q  <= cu_done;
        end
    end

    // ----------------------------------------
    // Descriptor broadcast
    // ----------------------------------------

    // Two stages, same depth as the flags
    // Clusters latch the input as it was while ap_start was held
    always_ff @(posedge ap_clk) begin
        base_s1    <= vertex_base;
        count_s1   <= vertex_count;
        desc_base  <= base_s1;
        desc_count <= count_s1;
    end

    // ----------------------------------------
    // Control FSM
    // ----------------------------------------

    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            current_state <= CTRL_RESET;
        end else begin
            current_state <= next_state;
        end
    end

    always_comb begin
        next_state = current_state;
        case (current_state)
            CTRL_RESET: begin
                next_state = CTRL_IDLE;
            end
            CTRL_IDLE: begin
                next_state = CTRL_SETUP;
            end
            CTRL_SETUP: begin
                // Accept only once every cluster is out of clearing
                if (start_q && !(|cu_setup_q)) begin
                    next_state = CTRL_READY;
                end
            end
            CTRL_READY: begin
                next_state = CTRL_START;
            end
            CTRL_START: begin
                next_state = CTRL_BUSY;
            end
            CTRL_BUSY: begin
                if (&cu_done_q) begin
                    next_state = CTRL_DONE;
                end
            end
            CTRL_DONE: begin
                // Chained restart, either continue or a fresh start
                if (continue_q || start_q) begin
                    next_state = CTRL_READY;
                end
            end
            default: begin
                next_state = CTRL_RESET;
            end
        endcase
    end

    // ----------------------------------------
    // Flag stages
    // ----------------------------------------

    // Stage one, flags per state
    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            ready_s1 <= 1'b0;
            done_s1  <= 1'b0;
            idle_s1  <= 1'b1;
            valid_s1 <= 1'b0;
        end else begin
            ready_s1 <= (current_state == CTRL_READY);
            done_s1  <= (current_state == CTRL_DONE);
            // Busy window READY through BUSY
            idle_s1  <= !(current_state == CTRL_READY ||
                          current_state == CTRL_START ||
                          current_state == CTRL_BUSY);
            // Descriptor live for the whole run
            valid_s1 <= (current_state == CTRL_START ||
                         current_state == CTRL_BUSY);
        end
    end

    // Stage two, drives the ports
    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            ap_ready   <= 1'b0;
            ap_done    <= 1'b0;
            ap_idle    <= 1'b1;
            desc_valid <= 1'b0;
        end else begin
            ap_ready   <= ready_s1;
            ap_done    <= done_s1;
            ap_idle    <= idle_s1;
            desc_valid <= valid_s1;
        end
    end

endmodule : kernel_control

`default_nettype wire

//--- verilog/glay_pkg.sv
`default_nettype none

package glay_pkg;

    // ----------------------------------------
    // Shared widths
    // ----------------------------------------

    // Vertex ids, descriptor base and count
    localparam int VERTEX_W = 16;

    // Partial sums and final result, wrapping modulo 2^SUM_W
    localparam int SUM_W = 32;

    // ----------------------------------------
    // Controller FSM
    // ----------------------------------------

    // ap_ctrl_chain sequence, SETUP waits on cluster clearing
    typedef enum logic [2:0] {
        CTRL_RESET,
        CTRL_IDLE,
        CTRL_SETUP,
        CTRL_READY,
        CTRL_START,
        CTRL_BUSY,
        CTRL_DONE
    } ctrl_state_t;

    // ----------------------------------------
    // Cluster FSM
    // ----------------------------------------

    // Clear after reset, then wait / walk / hold per run
    typedef enum logic [1:0] {
        CLUSTER_CLEAR,
        CLUSTER_WAIT,
        CLUSTER_WALK,
        CLUSTER_HOLD
    } cluster_state_t;

endpackage : glay_pkg

`default_nettype wire
